//--- ibuf_frontend_top.f
+incdir+rtl
rtl/frontend_pkg.sv
rtl/decode_pkg.sv
rtl/predecode_if.sv
rtl/predecode_align.sv
rtl/inst_buffer_bank.sv
rtl/inst_buffer.sv
rtl/decode_issue.sv
rtl/ibuf_frontend_top.sv
verification/ibuf_frontend_tb.sv

//--- rtl/decode_issue.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module decode_issue (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic                                             redirect,
    input  decode_pkg::fetch_bundle_t                        bundle,
    output logic                                             stall,
    input  logic                                             dec_ready,
    output logic [`IBUF_FETCH_WIDTH-1:0]                     dec_valid,
    output frontend_pkg::inst_t [`IBUF_FETCH_WIDTH-1:0]     dec_inst,
    output frontend_pkg::fsq_info_t [`IBUF_FETCH_WIDTH-1:0] dec_fsq_info,
    output logic                                             dec_fault
);
    import frontend_pkg::*;

    localparam int FW = `IBUF_FETCH_WIDTH;

    logic [FW-1:0]     valid_q;
    inst_t [FW-1:0]     inst_q;
    fsq_info_t [FW-1:0] info_q;
    logic              fault_q;
    logic              fault_hold; // Set after a fault until redirect.

    logic              load;
    logic [FW-1:0]     keep;
    logic              fault_seen;

    // Cut the bundle after the first faulting lane.
    always_comb begin : trunc
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < FW; i++) begin
            keep[i] = bundle.en[i] & ~seen;
            seen    = seen | (bundle.en[i] & bundle.fault[i]);
        end
        fault_seen = seen;
    end

    assign load  = ~(|valid_q) | dec_ready;
    assign stall = ~load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            fault_q    <= 1'b0;
            fault_hold <= 1'b0;
        end else if (redirect) begin
            valid_q    <= '0;
            fault_q    <= 1'b0;
            fault_hold <= 1'b0;
        end else if (load) begin
            if (fault_hold) begin
                valid_q <= '0; // Consumed but dropped.
                fault_q <= 1'b0;
            end else begin
                valid_q    <= keep;
                fault_q    <= fault_seen;
                fault_hold <= fault_seen;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            inst_q <= bundle.inst;
            info_q <= bundle.fsq_info;
        end
    end

    assign dec_valid    = valid_q;
    assign dec_inst     = inst_q;
    assign dec_fsq_info = info_q;
    assign dec_fault    = fault_q;

endmodule

//--- rtl/decode_pkg.sv
`include "ibuf_config.svh"

package decode_pkg;

    // One bank word.
    typedef struct packed {
        logic                   fault;
        frontend_pkg::fsq_info_t fsq_info;
        frontend_pkg::inst_t     inst;
    } ibuf_entry_t;

    // Up to IBUF_FETCH_WIDTH oldest entries, contiguous from lane 0.
    typedef struct packed {
        logic [`IBUF_FETCH_WIDTH-1:0]                          en;
        frontend_pkg::inst_t [`IBUF_FETCH_WIDTH-1:0]     inst;
        frontend_pkg::fsq_info_t [`IBUF_FETCH_WIDTH-1:0] fsq_info;
        logic [`IBUF_FETCH_WIDTH-1:0]                          fault;
    } fetch_bundle_t;

endpackage

//--- rtl/frontend_pkg.sv
`include "ibuf_config.svh"

package frontend_pkg;

    typedef logic [31:0] inst_t; // One instruction word.

    typedef logic [`FSQ_IDX_WIDTH-1:0] fsq_idx_t;

    // Slot of an instruction inside its fetch block.
    typedef logic [$clog2(`IBUF_BLOCK_INSTS)-1:0] blk_offset_t;

    typedef struct packed {
        fsq_idx_t    idx;
        blk_offset_t offset;
    } fsq_info_t;

endpackage

//--- rtl/ibuf_config.svh
`ifndef IBUF_CONFIG_SVH
`define IBUF_CONFIG_SVH

// Fetch side.
`define IBUF_BLOCK_INSTS 4
`define FSQ_IDX_WIDTH 4

// Decode side.
`define IBUF_FETCH_WIDTH 4

// Bank count must cover both block size and fetch width.
`define IBUF_BANK_NUM 4
`define IBUF_BANK_DEPTH 4
`define IBUF_BANK_IDX_W $clog2(`IBUF_BANK_DEPTH)
`define IBUF_SIZE (`IBUF_BANK_NUM * `IBUF_BANK_DEPTH)

`endif

//--- rtl/ibuf_frontend_top.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module ibuf_frontend_top (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic                                             redirect,
    input  logic                                             blk_valid,
    output logic                                             blk_ready,
    input  logic [`IBUF_BLOCK_INSTS-1:0]                     blk_mask,
    input  frontend_pkg::inst_t [`IBUF_BLOCK_INSTS-1:0]      blk_inst,
    input  frontend_pkg::fsq_idx_t                           blk_fsq_idx,
    input  logic                                             blk_iam,
    output logic [`IBUF_FETCH_WIDTH-1:0]                     dec_valid,
    output frontend_pkg::inst_t [`IBUF_FETCH_WIDTH-1:0]     dec_inst,
    output frontend_pkg::fsq_info_t [`IBUF_FETCH_WIDTH-1:0] dec_fsq_info,
    output logic                                             dec_fault,
    input  logic                                             dec_ready
);
    import decode_pkg::*;

    fetch_bundle_t bundle;
    logic          stall;

    predecode_if pd ();

    predecode_align i_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .blk_valid   (blk_valid),
        .blk_ready   (blk_ready),
        .blk_mask    (blk_mask),
        .blk_inst    (blk_inst),
        .blk_fsq_idx (blk_fsq_idx),
        .blk_iam     (blk_iam),
        .pd          (pd.aligner)
    );

    inst_buffer i_ibuf (
        .clk      (clk),
        .arst_n   (arst_n),
        .redirect (redirect),
        .pd       (pd.ibuf),
        .stall    (stall),
        .bundle   (bundle)
    );

    // Issue register toward decode.
    decode_issue i_issue (
        .clk          (clk),
        .arst_n       (arst_n),
        .redirect     (redirect),
        .bundle       (bundle),
        .stall        (stall),
        .dec_ready    (dec_ready),
        .dec_valid    (dec_valid),
        .dec_inst     (dec_inst),
        .dec_fsq_info (dec_fsq_info),
        .dec_fault    (dec_fault)
    );

endmodule

//--- rtl/inst_buffer.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module inst_buffer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      redirect,
    predecode_if.ibuf                 pd,
    input  logic                      stall,
    output decode_pkg::fetch_bundle_t bundle
);
    import decode_pkg::*;

    localparam int NB    = `IBUF_BANK_NUM;
    localparam int FW    = `IBUF_FETCH_WIDTH;
    localparam int BW    = $clog2(`IBUF_BANK_NUM);
    localparam int IDX_W = `IBUF_BANK_IDX_W;
    localparam int PTR_W = $clog2(`IBUF_SIZE);
    localparam int CNT_W = PTR_W + 1;

    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [IDX_W-1:0] windex [NB];
    logic [IDX_W-1:0] rindex [NB];

    ibuf_entry_t      wdata [NB];
    ibuf_entry_t      rdata [NB];

    logic             push;
    logic [NB-1:0]    we;
    logic [2*NB-1:0]  we_shift;
    logic [NB-1:0]    re;
    logic [2*NB-1:0]  re_shift;
    logic [FW-1:0]    offer_en;
    logic [CNT_W-1:0] offer_num;
    logic [CNT_W-1:0] pop_num;

    assign pd.full = (count + CNT_W'(pd.num)) > CNT_W'(`IBUF_SIZE);
    assign push    = pd.en[0] & ~pd.full;

    // Rotate lane enables onto the banks starting at the tail bank.
    assign we_shift = (2*NB)'(pd.en) << tail[BW-1:0];
    assign we       = (we_shift[NB-1:0] | we_shift[2*NB-1:NB]) & {NB{push}};

    assign offer_num = (count > CNT_W'(FW)) ? CNT_W'(FW) : count;
    assign pop_num   = stall ? '0 : offer_num;

    always_comb begin
        for (int i = 0; i < FW; i++) begin
            offer_en[i] = count > CNT_W'(i);
        end
    end

    assign re_shift = (2*NB)'(offer_en & {FW{~stall}}) << head[BW-1:0];
    assign re       = re_shift[NB-1:0] | re_shift[2*NB-1:NB];

    for (genvar j = 0; j < NB; j++) begin : g_bank
        logic [BW-1:0] lane;

        assign lane     = BW'(j) - tail[BW-1:0]; // Aligner lane landing in this bank.
        assign wdata[j] = '{fault:    pd.iam,
                            fsq_info: '{idx: pd.fsq_idx, offset: pd.offset[lane]},
                            inst:     pd.inst[lane]};

        inst_buffer_bank i_bank (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (we[j]),
            .waddr  (windex[j]),
            .raddr  (rindex[j]),
            .din    (wdata[j]),
            .dout   (rdata[j])
        );
    end

    for (genvar i = 0; i < FW; i++) begin : g_lane
        logic [BW-1:0] bank;

        assign bank               = head[BW-1:0] + BW'(i);
        assign bundle.en[i]       = offer_en[i];
        assign bundle.inst[i]     = rdata[bank].inst;
        assign bundle.fsq_info[i] = rdata[bank].fsq_info;
        assign bundle.fault[i]    = rdata[bank].fault;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            head  <= '0;
            tail  <= '0;
            for (int j = 0; j < NB; j++) begin
                windex[j] <= '0;
                rindex[j] <= '0;
            end
        end else if (redirect) begin
            count <= '0;
            head  <= '0;
            tail  <= '0;
            for (int j = 0; j < NB; j++) begin
                windex[j] <= '0;
                rindex[j] <= '0;
            end
        end else begin
            count <= count + (push ? CNT_W'(pd.num) : '0) - pop_num;
            head  <= head + pop_num[PTR_W-1:0];
            if (push) begin
                tail <= tail + PTR_W'(pd.num);
            end
            for (int j = 0; j < NB; j++) begin
                windex[j] <= windex[j] + IDX_W'(we[j]);
                rindex[j] <= rindex[j] + IDX_W'(re[j]);
            end
        end
    end

endmodule

//--- rtl/inst_buffer_bank.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module inst_buffer_bank (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         we,
    input  logic [`IBUF_BANK_IDX_W-1:0]  waddr,
    input  logic [`IBUF_BANK_IDX_W-1:0]  raddr,
    input  decode_pkg::ibuf_entry_t      din,
    output decode_pkg::ibuf_entry_t      dout
);
    import decode_pkg::*;

    ibuf_entry_t mem [`IBUF_BANK_DEPTH];

    assign dout = mem[raddr]; // Read is combinational.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `IBUF_BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= din;
        end
    end

endmodule

//--- rtl/predecode_align.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module predecode_align (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         redirect,
    input  logic                                         blk_valid,
    output logic                                         blk_ready,
    input  logic [`IBUF_BLOCK_INSTS-1:0]                 blk_mask,
    input  frontend_pkg::inst_t [`IBUF_BLOCK_INSTS-1:0]  blk_inst,
    input  frontend_pkg::fsq_idx_t                       blk_fsq_idx,
    input  logic                                         blk_iam,
    predecode_if.aligner                                 pd
);
    import frontend_pkg::*;

    localparam int B     = `IBUF_BLOCK_INSTS;
    localparam int NUM_W = $clog2(`IBUF_BLOCK_INSTS) + 1;

    inst_t [B-1:0]       c_inst;
    blk_offset_t [B-1:0] c_off;
    logic [NUM_W-1:0]    c_num;

    logic                valid_q;
    logic [NUM_W-1:0]    num_q;
    inst_t [B-1:0]       inst_q;
    blk_offset_t [B-1:0] off_q;
    fsq_idx_t            fsq_q;
    logic                iam_q;

    logic                accept;
    logic                xfer;

    // Pack set mask slots into the low lanes, oldest slot first.
    always_comb begin : compact
        logic [NUM_W-1:0] cnt;
        cnt    = '0;
        c_inst = '0;
        c_off  = '0;
        for (int s = 0; s < B; s++) begin
            if (blk_mask[s]) begin
                c_inst[cnt[NUM_W-2:0]] = blk_inst[s];
                c_off[cnt[NUM_W-2:0]]  = blk_offset_t'(s);
                cnt = cnt + 1'b1;
            end
        end
        c_num = cnt;
    end

    assign xfer      = valid_q & ~pd.full;
    assign blk_ready = ~valid_q | ~pd.full;
    assign accept    = blk_valid & blk_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            num_q   <= '0;
        end else if (redirect) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= |blk_mask; // Empty blocks are dropped here.
            num_q   <= c_num;
        end else if (xfer) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= c_inst;
            off_q  <= c_off;
            fsq_q  <= blk_fsq_idx;
            iam_q  <= blk_iam;
        end
    end

    always_comb begin
        for (int i = 0; i < B; i++) begin
            pd.en[i] = valid_q && (num_q > NUM_W'(i));
        end
    end

    assign pd.num     = num_q;
    assign pd.inst    = inst_q;
    assign pd.offset  = off_q;
    assign pd.fsq_idx = fsq_q;
    assign pd.iam     = iam_q;

endmodule

//--- rtl/predecode_if.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

interface predecode_if;
    import frontend_pkg::*;

    logic [`IBUF_BLOCK_INSTS-1:0]     en;     // Thermometer of num.
    logic [$clog2(`IBUF_BLOCK_INSTS):0] num;
    inst_t [`IBUF_BLOCK_INSTS-1:0]    inst;   // Compacted lanes.
    blk_offset_t [`IBUF_BLOCK_INSTS-1:0] offset; // Original slot per lane.
    fsq_idx_t                         fsq_idx;
    logic                             iam;
    logic                             full;

    modport aligner (output en, num, inst, offset, fsq_idx, iam, input full);
    modport ibuf (input en, num, inst, offset, fsq_idx, iam, output full);

endinterface

//--- run_sim.sh
#!/bin/sh
# Compile and run the instruction buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ibuf_frontend_tb \
    -f ibuf_frontend_top.f -o ibuf_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ibuf_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verification/ibuf_frontend_tb.sv
`timescale 1ns/100ps
`include "ibuf_config.svh"

module ibuf_frontend_tb;
    import frontend_pkg::*;
    import decode_pkg::*;

    localparam int B            = `IBUF_BLOCK_INSTS;
    localparam int FW           = `IBUF_FETCH_WIDTH;
    localparam int TOTAL_BLOCKS = 31; // Blocks sent over all tests.
    localparam int CYCLE_LIMIT  = TOTAL_BLOCKS * 8 + 200;

    logic               clk;
    logic               arst_n;
    logic               redirect;
    logic               blk_valid;
    logic               blk_ready;
    logic [B-1:0]       blk_mask;
    inst_t [B-1:0]      blk_inst;
    fsq_idx_t           blk_fsq_idx;
    logic               blk_iam;
    logic [FW-1:0]      dec_valid;
    inst_t [FW-1:0]     dec_inst;
    fsq_info_t [FW-1:0] dec_fsq_info;
    logic               dec_fault;
    logic               dec_ready;

    ibuf_entry_t exp_q[$];     // Instructions still owed to decode.
    logic        model_fault;  // Set once a faulting instruction is queued.
    logic [31:0] lfsr;
    fsq_idx_t    fsq_next;
    int          cyc = 0;

    ibuf_frontend_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .redirect     (redirect),
        .blk_valid    (blk_valid),
        .blk_ready    (blk_ready),
        .blk_mask     (blk_mask),
        .blk_inst     (blk_inst),
        .blk_fsq_idx  (blk_fsq_idx),
        .blk_iam      (blk_iam),
        .dec_valid    (dec_valid),
        .dec_inst     (dec_inst),
        .dec_fsq_info (dec_fsq_info),
        .dec_fault    (dec_fault),
        .dec_ready    (dec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_entry(input string name, input ibuf_entry_t got,
                               input ibuf_entry_t want);
        if (got.inst !== want.inst || got.fsq_info !== want.fsq_info) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name,
                     {got.fsq_info, got.inst}, {want.fsq_info, want.inst});
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, want);
            end_with_failure();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic inst_t random_word();
        inst_t w;
        logic  fb;
        for (int k = 0; k < 32; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w[k] = fb;
        end
        return w;
    endfunction

    // Present one block and queue its compacted instructions once it is taken.
    task automatic send_block(input logic [B-1:0] mask, input logic iam);
        inst_t [B-1:0] words;
        ibuf_entry_t   ent;
        for (int s = 0; s < B; s++) begin
            words[s] = random_word();
        end
        blk_valid   = 1'b1;
        blk_mask    = mask;
        blk_inst    = words;
        blk_fsq_idx = fsq_next;
        blk_iam     = iam;
        @(negedge clk);
        while (!blk_ready) @(negedge clk);
        for (int s = 0; s < B; s++) begin
            if (mask[s] && !model_fault) begin
                ent = '{fault: iam, fsq_info: '{idx: fsq_next, offset: s}, inst: words[s]};
                exp_q.push_back(ent);
                model_fault = iam; // Nothing after a fault reaches decode.
            end
        end
        @(posedge clk);
        #2;
        blk_valid = 1'b0;
        fsq_next  = fsq_next + 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        #2;
    endtask

    task automatic flush_pipeline();
        redirect = 1'b1;
        @(posedge clk);
        exp_q.delete();
        model_fault = 1'b0;
        #2;
        redirect = 1'b0;
    endtask

    // Consumed lanes are checked against the expected stream in order.
    always @(negedge clk) begin : watch_decode
        ibuf_entry_t got;
        ibuf_entry_t want;
        logic        fault_want;
        fault_want = 1'b0;
        if (dec_ready && dec_valid != '0) begin
            check_flag("dec_valid contiguous", (dec_valid & (dec_valid + 1'b1)) == '0, 1'b1);
            for (int i = 0; i < FW; i++) begin
                if (dec_valid[i]) begin
                    if (exp_q.size() == 0) begin
                        $display("Decode lane %0d issued an instruction that was not expected", i);
                        end_with_failure();
                    end else begin
                        want = exp_q.pop_front();
                        got  = '{fault: 1'b0, fsq_info: dec_fsq_info[i], inst: dec_inst[i]};
                        check_entry($sformatf("dec lane %0d", i), got, want);
                        fault_want = fault_want | want.fault;
                    end
                end
            end
            check_flag("dec_fault", dec_fault, fault_want);
        end
    end

    task automatic test_full_blocks();
        send_block(4'b1111, 1'b0);
        // Taken at the end of cycle 0 and seen by decode in cycle 3.
        repeat (2) @(negedge clk);
        check_flag("dec_valid[0]", dec_valid[0], 1'b0);
        @(negedge clk);
        check_flag("dec_valid[0]", dec_valid[0], 1'b1);
        @(posedge clk);
        #2;
        repeat (5) send_block(4'b1111, 1'b0);
        wait_drain();
    endtask

    task automatic test_holey_masks();
        send_block(4'b1010, 1'b0);
        send_block(4'b0111, 1'b0);
        send_block(4'b0000, 1'b0);
        send_block(4'b1001, 1'b0);
        send_block(4'b0000, 1'b0);
        send_block(4'b1000, 1'b0);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        dec_ready = 1'b0;
        repeat (6) send_block(4'b1111, 1'b0);
        // Issue register holds 4, buffer 16, aligner the sixth block.
        repeat (4) begin
            @(negedge clk);
            check_flag("blk_ready", blk_ready, 1'b0);
        end
        @(posedge clk);
        #2;
        dec_ready = 1'b1;
        wait_drain();
    endtask

    task automatic test_access_fault();
        send_block(4'b1111, 1'b0);
        send_block(4'b1110, 1'b1); // Fault on slot 1.
        send_block(4'b1111, 1'b0);
        send_block(4'b1111, 1'b0);
        wait_drain();
        repeat (8) @(posedge clk);
        #2;
        flush_pipeline();
    endtask

    task automatic test_redirect();
        // Buffer full and aligner held when the redirect arrives.
        dec_ready = 1'b0;
        repeat (6) send_block(4'b1111, 1'b0);
        flush_pipeline();
        repeat (4) begin
            @(negedge clk);
            check_flag("dec_valid any", |dec_valid, 1'b0);
        end
        check_flag("blk_ready", blk_ready, 1'b1);
        @(posedge clk);
        #2;
        dec_ready = 1'b1;
        send_block(4'b0110, 1'b0);
        send_block(4'b1111, 1'b0);
        send_block(4'b1011, 1'b0);
        wait_drain();
    endtask

    initial begin
        arst_n      = 1'b0;
        redirect    = 1'b0;
        blk_valid   = 1'b0;
        blk_mask    = '0;
        blk_inst    = '0;
        blk_fsq_idx = '0;
        blk_iam     = 1'b0;
        dec_ready   = 1'b1;
        lfsr        = 32'haf34c121;
        fsq_next    = '0;
        model_fault = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("blk_ready", blk_ready, 1'b1);
        check_flag("dec_valid any", |dec_valid, 1'b0);
        check_flag("dec_fault", dec_fault, 1'b0);
        @(posedge clk);
        #2;
        test_full_blocks();
        test_holey_masks();
        test_back_pressure();
        test_access_fault();
        test_redirect();
        $display("All tests passed");
        $finish;
    end

endmodule
